// ==== Bender.yml ====
package:
  name: ecc_alu

sources:
  - logic/ecc_alu_pkg.sv
  - logic/mod_add.sv
  - logic/mont_mul.sv
  - logic/ecc_alu.sv
  - target: test
    files:
      - bench/ecc_alu_props.sv
      - bench/ecc_alu_tb.sv

// ==== bench/ecc_alu_patterns.hex ====
# opcode swap_op swap_bit cin a b expected_r expected_r_swap, all hex
# opcode[2] picks curve25519, opcode[3] is ignored
0 0 0 0 1 2 3 0
0 0 0 0 ffffffff00000001000000000000000000000000fffffffffffffffffffffffe 2 1 0
8 0 0 1 ffffffff00000001000000000000000000000000fffffffffffffffffffffffe ffffffff00000001000000000000000000000000fffffffffffffffffffffffe ffffffff00000001000000000000000000000000fffffffffffffffffffffffe 0
4 0 0 1 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffec 5 5 0
c 0 0 1 10 20 31 0
1 0 0 0 3 5 f 0
1 0 0 0 ffffffff00000001000000000000000000000000fffffffffffffffffffffffe ffffffff00000001000000000000000000000000fffffffffffffffffffffffe 1 0
1 0 0 0 ffffffff00000001000000000000000000000000fffffffffffffffffffffffe 2 ffffffff00000001000000000000000000000000fffffffffffffffffffffffd 0
1 0 0 0 123456789abcdef 1 123456789abcdef 0
5 0 0 0 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffec 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffec 1 0
5 0 0 0 4000000000000000000000000000000000000000000000000000000000000000 2 13 0
5 0 0 0 ffffffff ffffffff fffffffe00000001 0
0 1 0 0 aaaa 5555 aaaa 5555
0 1 1 0 aaaa 5555 5555 aaaa
5 1 1 1 1234 abcd abcd 1234
2 0 0 0 7 9 0 0
3 0 0 1 7 9 0 0
e 0 0 0 1 1 0 0

// ==== bench/ecc_alu_props.sv ====
`timescale 1ns/1ps

module ecc_alu_props
    import ecc_alu_pkg::*;
(
    input logic                 clk,
    input logic                 rst,
    input logic                 en,
    input logic                 vld,
    input alu_status_t          status,
    input alu_state_t           state,
    input logic [alu_width-1:0] a_q,
    input logic [alu_width-1:0] b_q
);

    int fail_count = 0;  // assertion failures so far

    // result strobe is a single cycle
    assert property (@(posedge clk) disable iff (rst) vld |=> !vld)
    else
    begin
        $error("vld high for two cycles in a row");
        fail_count++;
    end

    // first cycle out of reset
    assert property (@(posedge clk) rst |=> (status == stat_idle && !vld))
    else
    begin
        $error("status not idle or vld set right after reset");
        fail_count++;
    end

    assert property (@(posedge clk) disable iff (rst)
        vld |-> (status == stat_done || status == stat_error))
    else
    begin
        $error("vld without done or error status");
        fail_count++;
    end

    // en while busy must not touch the captured operands
    assert property (@(posedge clk) disable iff (rst)
        (en && state != st_idle) |=> (a_q == $past(a_q) && b_q == $past(b_q)))
    else
    begin
        $error("en while busy changed the operand registers");
        fail_count++;
    end

endmodule

bind ecc_alu ecc_alu_props i_ecc_alu_props (
    .clk    (clk),
    .rst    (rst),
    .en     (en),
    .vld    (vld),
    .status (status),
    .state  (state),
    .a_q    (a_q),
    .b_q    (b_q)
);

// ==== bench/ecc_alu_tb.sv ====
`timescale 1ns/1ps

module ecc_alu_tb
    import ecc_alu_pkg::*;
();

    logic                 clk;
    logic                 rst;
    logic                 en;
    logic [3:0]           opcode;
    logic                 swap_op;
    logic                 swap_bit;
    logic [alu_width-1:0] a;
    logic [alu_width-1:0] b;
    logic                 cin;
    logic [alu_width-1:0] r;
    logic [alu_width-1:0] r_swap;
    logic                 vld;
    alu_status_t          status;

    integer               seed;         // gap generator
    int                   errors;       // total mismatches
    int                   n_pass;
    int                   n_fail;
    int                   n_mul;        // every odd mul gets a busy en burst
    int                   fd;
    int                   fields;
    int                   idx;
    int                   gap;
    string                line;
    logic [3:0]           v_op;
    logic                 v_so;
    logic                 v_sb;
    logic                 v_cin;
    logic [alu_width-1:0] v_a;
    logic [alu_width-1:0] v_b;
    logic [alu_width-1:0] v_r;
    logic [alu_width-1:0] v_rs;

    ecc_alu i_ecc_alu (
        .clk      (clk),
        .rst      (rst),
        .en       (en),
        .opcode   (opcode),
        .swap_op  (swap_op),
        .swap_bit (swap_bit),
        .a        (a),
        .b        (b),
        .cin      (cin),
        .r        (r),
        .r_swap   (r_swap),
        .vld      (vld),
        .status   (status)
    );

    always
    begin
        #5 clk = ~clk;  // 10 ns period
    end

    task automatic compare_value(input string name, input logic [alu_width-1:0] expected,
                                 input logic [alu_width-1:0] actual);
        if (actual !== expected)
        begin
            $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    // mismatches plus bound assertion failures
    function automatic int error_total();
        return errors + i_ecc_alu.i_ecc_alu_props.fail_count;
    endfunction

    // cycles from en edge to vld, 0 where the mul path leaves it open
    function automatic int expected_latency(input logic [3:0] op, input logic sw);
        if (sw)
            return 1;
        if (op[1:0] == op_add)
            return 3;
        if (op[1:0] == op_mul)
            return 0;
        return 1;  // inv, exp
    endfunction

    task automatic finish_test(input int num, input string what, input int errs_before);
        if (error_total() == errs_before)
        begin
            n_pass++;
            $display("test %0d %s: pass", num, what);
        end
        else
        begin
            n_fail++;
            $display("test %0d %s: fail", num, what);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // one operation, en edge through the idle cycle after vld

    task automatic run_vector(input int num, input logic [3:0] op, input logic so,
                              input logic sb, input logic c,
                              input logic [alu_width-1:0] va, input logic [alu_width-1:0] vb,
                              input logic [alu_width-1:0] er, input logic [alu_width-1:0] ers,
                              input bit jam);
        int          errs_before;
        int          lat;
        int          limit;
        int          cycles;
        alu_status_t exp_status;
        errs_before = error_total();
        lat         = expected_latency(op, so);
        limit       = (lat == 0) ? 1200 : 10;  // two montgomery passes fit easily
        exp_status  = (so || op[1:0] == op_add || op[1:0] == op_mul) ? stat_done : stat_error;
        opcode   = op;
        swap_op  = so;
        swap_bit = sb;
        cin      = c;
        a        = va;
        b        = vb;
        en       = 1'b1;
        @(posedge clk);  // en edge
        #1;
        a      = ~va;    // operands already captured
        b      = ~vb;
        cin    = ~c;
        en     = jam;    // busy en burst with other operands
        cycles = 1;
        while (!vld && cycles < limit)
        begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles >= 6)
                en = 1'b0;
        end
        en = 1'b0;
        if (!vld)
        begin
            $display("vector %0d: no vld within %0d cycles", num, limit);
            n_fail++;
            $display("tests: %0d passed, %0d failed", n_pass, n_fail);
            $display("Regression failed");
            $finish;
        end
        if (lat != 0)
            compare_value("latency", lat, cycles);
        compare_value("r", er, r);
        compare_value("r_swap", ers, r_swap);
        compare_value("status", exp_status, status);
        @(posedge clk);
        #1;
        compare_value("vld", 0, vld);            // one cycle pulse
        compare_value("status", stat_idle, status);
        finish_test(num, jam ? "vector, busy en" : "vector", errs_before);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence

    initial
    begin
        clk      = 1'b0;
        rst      = 1'b1;
        en       = 1'b0;
        opcode   = 4'h0;
        swap_op  = 1'b0;
        swap_bit = 1'b0;
        cin      = 1'b0;
        a        = '0;
        b        = '0;
        seed     = 32'h348d;
        errors   = 0;
        n_pass   = 0;
        n_fail   = 0;
        n_mul    = 0;
        idx      = 0;
        repeat (10) @(posedge clk);
        #1 rst = 1'b0;
        repeat (5)
        begin
            @(posedge clk);
            #1;
            compare_value("vld", 0, vld);
            compare_value("status", stat_idle, status);
        end
        finish_test(0, "reset idle", 0);
        fd = $fopen("bench/ecc_alu_patterns.hex", "r");
        if (fd == 0)
        begin
            $display("pattern file bench/ecc_alu_patterns.hex could not be opened");
            $display("Regression failed");
            $finish;
        end
        while (!$feof(fd))
        begin
            line = "";
            void'($fgets(line, fd));
            fields = $sscanf(line, "%h %h %h %h %h %h %h %h",
                             v_op, v_so, v_sb, v_cin, v_a, v_b, v_r, v_rs);
            if (fields == 8)
            begin
                idx++;
                gap = $unsigned($random(seed)) % 4;  // 0..3 idle cycles
                repeat (gap)
                begin
                    @(posedge clk);
                    #1;
                end
                if (!v_so && v_op[1:0] == op_mul)
                    n_mul++;
                run_vector(idx, v_op, v_so, v_sb, v_cin, v_a, v_b, v_r, v_rs,
                           !v_so && v_op[1:0] == op_mul && n_mul[0]);
            end
            else if (fields > 0)
            begin
                $display("pattern line after vector %0d is incomplete", idx);
                errors++;
            end
        end
        $fclose(fd);
        $display("tests: %0d passed, %0d failed", n_pass, n_fail);
        if (error_total() == 0 && n_fail == 0 && idx > 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

// ==== list.f ====
logic/ecc_alu_pkg.sv
logic/mod_add.sv
logic/mont_mul.sv
logic/ecc_alu.sv
bench/ecc_alu_props.sv
bench/ecc_alu_tb.sv

// ==== logic/ecc_alu.sv ====
`timescale 1ns/1ps

module ecc_alu
    import ecc_alu_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 en,
    input  logic [3:0]           opcode,   // [1:0] op, [2] curve, [3] unused
    input  logic                 swap_op,  // beats the opcode
    input  logic                 swap_bit,
    input  logic [alu_width-1:0] a,
    input  logic [alu_width-1:0] b,
    input  logic                 cin,
    output logic [alu_width-1:0] r,
    output logic [alu_width-1:0] r_swap,
    output logic                 vld,
    output alu_status_t          status
);

    alu_state_t           state;
    logic                 en_idle;     // en sampled only in idle
    logic [alu_width-1:0] a_q;
    logic [alu_width-1:0] b_q;
    logic                 cin_q;
    logic                 swap_bit_q;
    logic [alu_width-1:0] mod_q;       // field prime of the chosen curve
    logic [alu_width-1:0] r2_q;        // R^2 mod p for that curve
    logic [alu_width-1:0] prod_q;      // first montgomery pass
    logic                 add_start;
    logic                 mul_start;
    logic [alu_width-1:0] add_sum;
    logic                 add_vld;
    logic [alu_width-1:0] mul_a;
    logic [alu_width-1:0] mul_b;
    logic [alu_width-1:0] mul_r;
    logic                 mul_vld;

    assign en_idle = en && (state == st_idle);

    ////////////////////////////////////////////////////////////////////////////
    // capture on the en edge

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            a_q        <= '0;
            b_q        <= '0;
            cin_q      <= 1'b0;
            swap_bit_q <= 1'b0;
        end
        else if (en_idle)
        begin
            a_q        <= a;
            b_q        <= b;
            cin_q      <= cin;
            swap_bit_q <= swap_bit;
        end
    end

    always_ff @(posedge clk)
    begin
        if (en_idle)
        begin
            mod_q <= opcode[2] ? x25519_mod : p256_mod;
            r2_q  <= opcode[2] ? x25519_r2 : p256_r2;
        end
        if (state == st_mul && mul_vld)
            prod_q <= mul_r;   // a*b*R^-1, fed back for normalize
    end

    ////////////////////////////////////////////////////////////////////////////
    // sequencer

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state     <= st_idle;
            add_start <= 1'b0;
            mul_start <= 1'b0;
        end
        else
        begin
            add_start <= 1'b0;  // one cycle pulses
            mul_start <= 1'b0;
            case (state)
                st_idle:
                    if (en)
                    begin
                        if (swap_op)
                            state <= st_swap;
                        else if (opcode[1:0] == op_add)
                        begin
                            state     <= st_add;
                            add_start <= 1'b1;
                        end
                        else if (opcode[1:0] == op_mul)
                        begin
                            state     <= st_mul;
                            mul_start <= 1'b1;
                        end
                        else
                            state <= st_err; // inv, exp
                    end
                st_add:
                    if (add_vld)
                        state <= st_idle;
                st_mul:
                    if (mul_vld)
                    begin
                        state     <= st_norm;
                        mul_start <= 1'b1;  // second pass with R^2
                    end
                st_norm:
                    if (mul_vld)
                        state <= st_idle;
                default: state <= st_idle;  // swap and err last one cycle
            endcase
        end
    end

    // normalize pass multiplies by R^2 to drop the R^-1
    assign mul_a = (state == st_norm) ? prod_q : a_q;
    assign mul_b = (state == st_norm) ? r2_q : b_q;

    mod_add i_mod_add (
        .clk   (clk),
        .rst   (rst),
        .start (add_start),
        .a     (a_q),
        .b     (b_q),
        .cin   (cin_q),
        .m     (mod_q),
        .sum   (add_sum),
        .vld   (add_vld)
    );

    mont_mul i_mont_mul (
        .clk   (clk),
        .rst   (rst),
        .start (mul_start),
        .a     (mul_a),
        .b     (mul_b),
        .m     (mod_q),
        .r     (mul_r),
        .vld   (mul_vld)
    );

    ////////////////////////////////////////////////////////////////////////////
    // result combiner

    assign vld = (state == st_add && add_vld) || (state == st_norm && mul_vld) ||
                 (state == st_swap) || (state == st_err);

    always_comb
    begin
        r      = '0;  // also the error result
        r_swap = '0;
        case (state)
            st_swap:
            begin
                r      = swap_bit_q ? b_q : a_q;
                r_swap = swap_bit_q ? a_q : b_q;
            end
            st_add:  r = add_vld ? add_sum : '0;
            st_norm: r = mul_vld ? mul_r : '0;
            default: r = '0;
        endcase
    end

    assign status = (state == st_idle) ? stat_idle  :
                    !vld               ? stat_busy  :
                    (state == st_err)  ? stat_error : stat_done;

endmodule

// ==== logic/ecc_alu_pkg.sv ====
package ecc_alu_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // datapath sizing

    localparam int alu_width = 256;               // operand and result width
    localparam int cnt_width = $clog2(alu_width); // mont_mul bit counter

    ////////////////////////////////////////////////////////////////////////////
    // curve constants

    // p256 field prime
    localparam logic [alu_width-1:0] p256_mod =
        256'hffffffff_00000001_00000000_00000000_00000000_ffffffff_ffffffff_ffffffff;

    // 2^512 mod p256, montgomery normalization
    localparam logic [alu_width-1:0] p256_r2 =
        256'h00000004_fffffffd_ffffffff_fffffffe_fffffffb_ffffffff_00000000_00000003;

    // 2^255 - 19
    localparam logic [alu_width-1:0] x25519_mod =
        256'h7fffffff_ffffffff_ffffffff_ffffffff_ffffffff_ffffffff_ffffffff_ffffffed;

    localparam logic [alu_width-1:0] x25519_r2 = 256'd1444; // 2^512 mod 2^255-19

    ////////////////////////////////////////////////////////////////////////////
    // opcode[1:0] encodings

    localparam logic [1:0] op_add = 2'b00; // modular add with carry in
    localparam logic [1:0] op_mul = 2'b01; // montgomery mul plus normalize
    localparam logic [1:0] op_inv = 2'b10; // not served, error
    localparam logic [1:0] op_exp = 2'b11; // not served, error

    // sequencer states
    typedef enum logic [2:0] {
        st_idle,
        st_add,
        st_mul,   // first pass a*b*R^-1
        st_norm,  // second pass with R^2
        st_swap,
        st_err
    } alu_state_t;

    // host status, same code points as the old wrapper
    typedef enum logic [1:0] {
        stat_idle  = 2'b00,
        stat_busy  = 2'b01,
        stat_done  = 2'b10,
        stat_error = 2'b11
    } alu_status_t;

endpackage

// ==== logic/mod_add.sv ====
`timescale 1ns/1ps

module mod_add
    import ecc_alu_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  logic [alu_width-1:0] a,
    input  logic [alu_width-1:0] b,
    input  logic                 cin,
    input  logic [alu_width-1:0] m,
    output logic [alu_width-1:0] sum,
    output logic                 vld
);

    logic [alu_width:0]   sum_q;  // stage one, carry kept on top
    logic [alu_width-1:0] m_q;
    logic                 s1_vld;
    logic [alu_width:0]   diff;   // sum_q - m, msb is the borrow

    // sum_q < 2m, so a clear borrow leaves a result below m
    assign diff = sum_q - {1'b0, m_q};

    // pipeline valid bits
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            s1_vld <= 1'b0;
            vld    <= 1'b0;
        end
        else
        begin
            s1_vld <= start;
            vld    <= s1_vld; // two cycles after start
        end
    end

    always_ff @(posedge clk)
    begin
        if (start)
        begin
            sum_q <= {1'b0, a} + {1'b0, b} + {{alu_width{1'b0}}, cin}; // full width
            m_q   <= m;
        end
        if (s1_vld)
            sum <= diff[alu_width] ? sum_q[alu_width-1:0] : diff[alu_width-1:0];
    end

endmodule

// ==== logic/mont_mul.sv ====
`timescale 1ns/1ps

module mont_mul
    import ecc_alu_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  logic [alu_width-1:0] a,
    input  logic [alu_width-1:0] b,
    input  logic [alu_width-1:0] m,
    output logic [alu_width-1:0] r,
    output logic                 vld
);

    ////////////////////////////////////////////////////////////////////////////
    // operand and accumulator registers

    logic [alu_width-1:0] a_q;     // shifted right one bit per step
    logic [alu_width-1:0] b_q;
    logic [alu_width-1:0] m_q;
    logic [alu_width:0]   acc;     // stays below 2m
    logic [cnt_width-1:0] cnt;     // step index
    logic                 busy;    // bit loop running
    logic                 fin;     // final subtract cycle

    logic [alu_width+1:0] add_b;   // acc plus b when the a bit is set
    logic [alu_width+1:0] add_m;   // plus m when odd, makes it even
    logic [alu_width:0]   sub_m;   // acc - m, msb is the borrow

    assign add_b = {1'b0, acc} + (a_q[0] ? {2'b00, b_q} : '0);
    assign add_m = add_b + (add_b[0] ? {2'b00, m_q} : '0);
    assign sub_m = acc - {1'b0, m_q};

    ////////////////////////////////////////////////////////////////////////////
    // control

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy <= 1'b0;
            fin  <= 1'b0;
            vld  <= 1'b0;
            cnt  <= '0;
        end
        else
        begin
            vld <= 1'b0;
            if (start && !busy && !fin)  // restarts held off while running
            begin
                busy <= 1'b1;
                cnt  <= '0;
            end
            else if (busy)
            begin
                cnt <= cnt + 1'b1;
                if (cnt == cnt_width'(alu_width - 1)) // last bit of a
                begin
                    busy <= 1'b0;
                    fin  <= 1'b1;
                end
            end
            else if (fin)
            begin
                fin <= 1'b0;
                vld <= 1'b1;   // r presented with this pulse
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // datapath

    always_ff @(posedge clk)
    begin
        if (start && !busy && !fin)
        begin
            a_q <= a;
            b_q <= b;
            m_q <= m;
            acc <= '0;
        end
        else if (busy)
        begin
            a_q <= a_q >> 1;
            acc <= add_m[alu_width+1:1]; // exact halving
        end
        if (fin)
            r <= sub_m[alu_width] ? acc[alu_width-1:0] : sub_m[alu_width-1:0];
    end

endmodule
